// ==== coreArray.sv ====
/* Word array shared by both phases.
   Two combinational read ports and one synchronous preload write port */
`include "sbusMem_params.svh"

module coreArray (
  input  logic                      SBUS,
  input  logic                      loadEn,
  input  logic [`MEM_ADDR_BITS-1:0] loadAddr,
  input  sbusPkg::sbusWord_t        loadData,
  input  logic [`MEM_ADDR_BITS-1:0] rdAddrA,
  input  logic [`MEM_ADDR_BITS-1:0] rdAddrB,
  output sbusPkg::sbusWord_t        rdDataA,
  output sbusPkg::sbusWord_t        rdDataB
);

  import sbusPkg::*;

  // Storage, one word per entry
  sbusWord_t mem [0:`MEM_DEPTH-1];

  // Preload write lands on the next edge
  always_ff @(posedge SBUS) begin
    if (loadEn) begin
      mem[loadAddr] <= loadData;
    end
  end

  // Both phases may read in the same cycle
  assign rdDataA = mem[rdAddrA];
  assign rdDataB = mem[rdAddrB];

endmodule

// ==== memPhase.sv ====
/* One phase of the core memory, serving quadword read cycles.
   Advances only on its tick; drives ACKN, VALID, data and parity per word */
`include "sbusMem_params.svh"

module memPhase (
  input  logic                      SBUS,
  input  logic                      reset,
  input  logic                      tick,
  input  sbusPkg::sbusReq_t         req,
  input  sbusPkg::sbusWord_t        rdData,
  output logic [`MEM_ADDR_BITS-1:0] rdAddr,
  output sbusPkg::sbusResp_t        resp
);

  import sbusPkg::*;

  typedef enum logic [2:0] {
    stIdle,
    stAck1,
    stAck2,
    stRead,
    stShift,
    stWaitIdle
  } phaseState_t;

  phaseState_t state;
  phaseState_t nextState;

  // Mask bits still to serve, bit 0 is the current word
  logic [0:`QUAD_WORDS-1] toAck;

  // Quadword base and running word offset
  sbusAddr_u curAddr;

  // Array index from the low bits of the current word address
  assign rdAddr = curAddr.word[36-`MEM_ADDR_BITS:35];

  // Next state, only taken on a tick
  always_comb begin
    nextState = state;
    case (state)
      stIdle: begin
        // Empty first slot goes straight to shifting
        if (req.start) begin
          nextState = req.rq[0] ? stAck1 : stShift;
        end
      end
      stAck1: nextState = stAck2;
      stAck2: nextState = stRead;
      stRead: nextState = stShift;
      stShift: begin
        // Look at the bit about to move into slot 0
        if (toAck[1]) begin
          nextState = stAck1;
        end else if (toAck[1:`QUAD_WORDS-1] == '0) begin
          nextState = stWaitIdle;
        end
        // Otherwise keep shifting cleared bits through
      end
      stWaitIdle: nextState = stIdle;
      default: nextState = stIdle;
    endcase
  end

  // Control state and response outputs
  always_ff @(posedge SBUS) begin
    if (reset) begin
      state <= stIdle;
      toAck <= '0;
      resp  <= '0;
    end else if (tick) begin
      state <= nextState;
      case (state)
        stIdle: begin
          if (req.start) begin
            toAck <= req.rq;
          end
        end
        // ACKN stays up through ack2
        stAck1: resp.ackn <= 1'b1;
        stRead: begin
          resp.ackn    <= 1'b0;
          resp.valid   <= 1'b1;
          resp.d       <= rdData;
          resp.dataPar <= ^rdData;
        end
        stShift: begin
          // VALID, data and parity last one tick
          resp.valid   <= 1'b0;
          resp.d       <= '0;
          resp.dataPar <= 1'b0;
          toAck        <= toAck << 1;
        end
        default: ;
      endcase
    end
  end

  // Address payload, latched at START and stepped after each read
  always_ff @(posedge SBUS) begin
    if (tick) begin
      if (state == stIdle && req.start) begin
        curAddr <= req.adr;
      end else if (state == stRead) begin
        // Offset wraps inside the quadword, base is untouched
        curAddr.quad.wo <= curAddr.quad.wo + 2'd1;
      end
    end
  end

endmodule

// ==== phaseTimer.sv ====
/* Generates the A and B phase ticks as clock enables on SBUS.
   Each tick toggles every cycle and realigns when its START rises */
module phaseTimer (
  input  logic SBUS,
  input  logic reset,
  input  logic startA,
  input  logic startB,
  output logic aTick,
  output logic bTick
);

  // Bit 0 is phase A, bit 1 is phase B
  logic [1:0] start;
  logic [1:0] startDly;
  logic [1:0] startRise;
  logic [1:0] toggle;

  assign start = {startB, startA};

  // Rising START seen against last cycle's level
  assign startRise = start & ~startDly;

  always_ff @(posedge SBUS) begin
    if (reset) begin
      startDly <= '0;
      toggle   <= '0;
    end else begin
      startDly <= start;
      // Clear on a new request, else flip every cycle
      // so the first tick lands two cycles after the rise
      toggle   <= ~toggle & ~startRise;
    end
  end

  // Each phase advances on its own toggle
  assign aTick = toggle[0];
  assign bTick = toggle[1];

endmodule

// ==== runSim.sh ====
#!/bin/sh
# Build with Verilator, run, and judge the result from the simulation log
cd "$(dirname "$0")" || exit 1
rm -f sim.log build.log

verilator --binary --timing -Wno-fatal --top-module sbusMemoryTb \
  -f sbusMemory.f -Mdir obj_dir -o sbusMemorySim > build.log 2>&1 \
  && ./obj_dir/sbusMemorySim > sim.log 2>&1 \
  || { echo "Build or simulation reported an error"; cat build.log sim.log 2>/dev/null; }

grep -q '\*\*\* PASSED \*\*\*' sim.log 2>/dev/null \
  && { echo "Simulation passed"; exit 0; } \
  || { echo "Simulation failed, see sim.log"; exit 1; }

// ==== sbusMem_params.svh ====
/* Sizing macros for the emulated core memory.
   Included by the package and by every module that sizes a port or array */
`ifndef SBUS_MEM_PARAMS_SVH
`define SBUS_MEM_PARAMS_SVH

// Bits in one memory word, numbered 0 to 35 as on the bus
`define WORD_BITS 36

// Words per quadword, also the width of the request mask
`define QUAD_WORDS 4

// Low word address bits that index the simulated memory
`define MEM_ADDR_BITS 12

// Number of words held by the array
`define MEM_DEPTH (1 << `MEM_ADDR_BITS)

`endif

// ==== sbusMemory.f ====
+incdir+.
sbusPkg.sv
phaseTimer.sv
memPhase.sv
coreArray.sv
sbusMemory.sv
sbusMemoryTb.sv

// ==== sbusMemory.sv ====
/* Top level of the two-phase core memory on the synchronous bus.
   Requests enter per phase; load port is for preload while both phases idle */
`include "sbusMem_params.svh"

module sbusMemory (
  input  logic                      SBUS,
  input  logic                      reset,
  input  sbusPkg::sbusReq_t         reqA,
  input  sbusPkg::sbusReq_t         reqB,
  input  logic                      loadEn,
  input  logic [`MEM_ADDR_BITS-1:0] loadAddr,
  input  sbusPkg::sbusWord_t        loadData,
  output sbusPkg::sbusResp_t        respA,
  output sbusPkg::sbusResp_t        respB
);

  import sbusPkg::*;

  // Phase enables
  logic aTick;
  logic bTick;

  // Read paths between phases and array
  logic [`MEM_ADDR_BITS-1:0] rdAddrA;
  logic [`MEM_ADDR_BITS-1:0] rdAddrB;
  sbusWord_t                 rdDataA;
  sbusWord_t                 rdDataB;

  // Ticks realign on each phase's START
  phaseTimer timer_i (
    .SBUS   (SBUS),
    .reset  (reset),
    .startA (reqA.start),
    .startB (reqB.start),
    .aTick  (aTick),
    .bTick  (bTick)
  );

  coreArray array_i (
    .SBUS     (SBUS),
    .loadEn   (loadEn),
    .loadAddr (loadAddr),
    .loadData (loadData),
    .rdAddrA  (rdAddrA),
    .rdAddrB  (rdAddrB),
    .rdDataA  (rdDataA),
    .rdDataB  (rdDataB)
  );

  // A phase
  memPhase phaseA (
    .SBUS   (SBUS),
    .reset  (reset),
    .tick   (aTick),
    .req    (reqA),
    .rdData (rdDataA),
    .rdAddr (rdAddrA),
    .resp   (respA)
  );

  // B phase
  memPhase phaseB (
    .SBUS   (SBUS),
    .reset  (reset),
    .tick   (bTick),
    .req    (reqB),
    .rdData (rdDataB),
    .rdAddr (rdAddrB),
    .resp   (respB)
  );

endmodule

// ==== sbusMemoryTb.sv ====
/* Self-checking testbench for the two-phase core memory.
   Preloads the array from an LFSR, then applies a table of read requests
   and checks pulse counts, word order, data and parity on both phases */
`include "sbusMem_params.svh"

module sbusMemoryTb;

  timeunit 1ns;
  timeprecision 1ps;

  import sbusPkg::*;

  localparam int CLK_HALF      = 20;
  localparam int WORD_TIMEOUT  = 200;
  // Covers the wait and idle ticks after the last word, two cycles per tick
  localparam int QUIET_CYCLES  = 16;
  localparam int NUM_STIM      = 12;
  localparam int MAX_WORDS     = 8;
  localparam logic [31:0] LFSR_SEED = 32'h5492a2e1;

  // Phase select, bit 0 is A and bit 1 is B
  localparam logic [1:0] SEL_A  = 2'b01;
  localparam logic [1:0] SEL_B  = 2'b10;
  localparam logic [1:0] SEL_AB = 2'b11;

  // One table row: which phases, word mask (bit 0 first), word address
  typedef struct packed {
    logic [1:0]             sel;
    logic [0:`QUAD_WORDS-1] mask;
    logic [23:0]            adr;
  } stimEntry_t;

  logic                      SBUS;
  logic                      reset;
  sbusReq_t                  reqA;
  sbusReq_t                  reqB;
  logic                      loadEn;
  logic [`MEM_ADDR_BITS-1:0] loadAddr;
  sbusWord_t                 loadData;
  sbusResp_t                 respA;
  sbusResp_t                 respB;

  // Reference copy of the array contents
  sbusWord_t  model [0:`MEM_DEPTH-1];
  stimEntry_t stimTable [0:NUM_STIM-1];
  logic [31:0] lfsr;

  // Monitor state, index 0 is phase A and 1 is phase B
  logic      prevAckn  [0:1] = '{1'b0, 1'b0};
  logic      prevValid [0:1] = '{1'b0, 1'b0};
  int        ackCount  [0:1] = '{0, 0};
  int        validCount[0:1] = '{0, 0};
  sbusWord_t holdD     [0:1];
  logic      holdP     [0:1];
  sbusWord_t gotD      [0:1][0:MAX_WORDS-1];
  logic      gotP      [0:1][0:MAX_WORDS-1];

  sbusMemory dut_i (
    .SBUS     (SBUS),
    .reset    (reset),
    .reqA     (reqA),
    .reqB     (reqB),
    .loadEn   (loadEn),
    .loadAddr (loadAddr),
    .loadData (loadData),
    .respA    (respA),
    .respB    (respB)
  );

  initial begin
    SBUS = 1'b0;
    forever #CLK_HALF SBUS = ~SBUS;
  end

  // Taps 32, 22, 2, 1
  function automatic logic [31:0] lfsrNext(input logic [31:0] s);
    logic fb;
    fb = s[31] ^ s[21] ^ s[1] ^ s[0];
    return {s[30:0], fb};
  endfunction

  // Even parity by walking every bit of the word
  function automatic logic evenParity(input sbusWord_t w);
    logic p;
    p = 1'b0;
    for (int b = 0; b < `WORD_BITS; b++) begin
      p = p ^ w[b];
    end
    return p;
  endfunction

  // Array index of word k: same base, offset steps mod 4 within the quadword
  function automatic logic [`MEM_ADDR_BITS-1:0] wordIndex(input logic [23:0] adr,
                                                          input int k);
    sbusAddr_u a;
    logic [34:35] wo;
    a.word = adr;
    wo = a.quad.wo + k[1:0];
    return {a.quad.base[36-`MEM_ADDR_BITS:33], wo};
  endfunction

  function automatic string phaseName(input int ph);
    return (ph == 0) ? "A" : "B";
  endfunction

  task automatic failRun(input string what);
    $display("%s", what);
    $display("*** FAILED ***");
    $fatal(1, "Stopping at first error");
  endtask

  task automatic checkValue(input string name, input logic [63:0] got,
                            input logic [63:0] expected);
    if (got !== expected) begin
      failRun($sformatf("Fail %s: got 0x%0h, expected 0x%0h", name, got, expected));
    end
  endtask

  // Counts pulses and captures each word while VALID is up
  always @(negedge SBUS) begin
    sbusResp_t r;
    for (int ph = 0; ph < 2; ph++) begin
      r = (ph == 0) ? respA : respB;
      if (r.ackn === 1'b1 && prevAckn[ph] !== 1'b1) begin
        ackCount[ph] = ackCount[ph] + 1;
      end
      if (r.valid === 1'b1) begin
        if (prevValid[ph] !== 1'b1) begin
          // ACKN of this word must already have been seen
          checkValue($sformatf("resp%s.ackn count at VALID", phaseName(ph)),
                     64'(ackCount[ph]), 64'(validCount[ph] + 1));
        end
        holdD[ph] = r.d;
        holdP[ph] = r.dataPar;
      end else if (prevValid[ph] === 1'b1) begin
        // Falling VALID ends the word
        if (validCount[ph] < MAX_WORDS) begin
          gotD[ph][validCount[ph]] = holdD[ph];
          gotP[ph][validCount[ph]] = holdP[ph];
        end
        validCount[ph] = validCount[ph] + 1;
      end
      prevAckn[ph]  = r.ackn;
      prevValid[ph] = r.valid;
    end
  end

  task automatic fillTable();
    stimTable = '{
      '{SEL_A,  4'b1111, 24'h000100},   // aligned full quadword
      '{SEL_B,  4'b1111, 24'h7A3206},   // starts at offset 2
      '{SEL_A,  4'b1111, 24'h010FF3},   // offset 3, wraps at once
      '{SEL_A,  4'b1001, 24'h000455},
      '{SEL_B,  4'b0001, 24'h0003A2},
      '{SEL_A,  4'b0110, 24'h123C7D},
      '{SEL_A,  4'b0000, 24'h000044},   // no words at all
      '{SEL_A,  4'b1000, 24'h000041},
      '{SEL_AB, 4'b1111, 24'h000301},
      '{SEL_AB, 4'b1011, 24'h0204C2},
      '{SEL_B,  4'b0000, 24'h000010},
      '{SEL_B,  4'b1100, 24'h00FFFF}
    };
  endtask

  // One load per cycle; 36 LFSR steps build each word
  task automatic preload();
    sbusWord_t w;
    for (int i = 0; i < `MEM_DEPTH; i++) begin
      for (int b = 0; b < `WORD_BITS; b++) begin
        lfsr = lfsrNext(lfsr);
        w[b] = lfsr[0];
      end
      model[i] = w;
      loadEn   = 1'b1;
      loadAddr = `MEM_ADDR_BITS'(i);
      loadData = w;
      @(negedge SBUS);
    end
    loadEn = 1'b0;
  endtask

  // Idle phases hold ACKN, VALID, data and parity low
  task automatic checkQuiet();
    checkValue("respA.ackn", 64'(respA.ackn), 64'd0);
    checkValue("respA.valid", 64'(respA.valid), 64'd0);
    checkValue("respA.dataPar", 64'(respA.dataPar), 64'd0);
    checkValue("respA.d", 64'(respA.d), 64'd0);
    checkValue("respB.ackn", 64'(respB.ackn), 64'd0);
    checkValue("respB.valid", 64'(respB.valid), 64'd0);
    checkValue("respB.dataPar", 64'(respB.dataPar), 64'd0);
    checkValue("respB.d", 64'(respB.d), 64'd0);
  endtask

  task automatic waitForWords(input int expA, input int expB);
    int cycles;
    cycles = 0;
    while (validCount[0] < expA || validCount[1] < expB) begin
      @(posedge SBUS);
      cycles = cycles + 1;
      if (cycles > WORD_TIMEOUT) begin
        failRun($sformatf("Timed out waiting for words: A got %0d of %0d, B got %0d of %0d",
                          validCount[0], expA, validCount[1], expB));
      end
    end
  endtask

  task automatic checkPhase(input int ph, input int expWords, input logic [23:0] adr);
    logic [`MEM_ADDR_BITS-1:0] idx;
    string pn;
    pn = phaseName(ph);
    checkValue($sformatf("resp%s.ackn pulses", pn), 64'(ackCount[ph]), 64'(expWords));
    checkValue($sformatf("resp%s.valid pulses", pn), 64'(validCount[ph]), 64'(expWords));
    for (int k = 0; k < expWords; k++) begin
      idx = wordIndex(adr, k);
      checkValue($sformatf("resp%s.d word %0d", pn, k), 64'(gotD[ph][k]), 64'(model[idx]));
      checkValue($sformatf("resp%s.dataPar word %0d", pn, k),
                 64'(gotP[ph][k]), 64'(evenParity(model[idx])));
    end
  endtask

  task automatic runEntry(input stimEntry_t e);
    logic [23:0] adrB;
    int expA;
    int expB;
    // Both phases at once read different quadwords
    adrB = (e.sel == SEL_AB) ? (e.adr ^ 24'h000800) : e.adr;
    expA = e.sel[0] ? $countones(e.mask) : 0;
    expB = e.sel[1] ? $countones(e.mask) : 0;
    @(posedge SBUS);
    for (int ph = 0; ph < 2; ph++) begin
      ackCount[ph]   = 0;
      validCount[ph] = 0;
    end
    @(negedge SBUS);
    if (e.sel[0]) begin
      reqA.start    = 1'b1;
      reqA.rq       = e.mask;
      reqA.adr.word = e.adr;
    end
    if (e.sel[1]) begin
      reqB.start    = 1'b1;
      reqB.rq       = e.mask;
      reqB.adr.word = adrB;
    end
    // Rise seen, toggle realigns, START sampled on the third edge
    repeat (3) @(posedge SBUS);
    @(negedge SBUS);
    reqA = '0;
    reqB = '0;
    waitForWords(expA, expB);
    repeat (QUIET_CYCLES) @(posedge SBUS);
    checkPhase(0, expA, e.adr);
    checkPhase(1, expB, adrB);
    @(negedge SBUS);
    checkQuiet();
  endtask

  initial begin
    reset    = 1'b1;
    reqA     = '0;
    reqB     = '0;
    loadEn   = 1'b0;
    loadAddr = '0;
    loadData = '0;
    lfsr     = LFSR_SEED;
    fillTable();
    repeat (3) @(negedge SBUS);
    reset = 1'b0;
    checkQuiet();
    preload();
    checkQuiet();
    for (int i = 0; i < NUM_STIM; i++) begin
      runEntry(stimTable[i]);
    end
    $display("*** PASSED ***");
    $finish;
  end

endmodule

// ==== sbusPkg.sv ====
/* Bus word, address and per-phase request/response types.
   Modules import it in their bodies and use scoped names on their ports */
`include "sbusMem_params.svh"

package sbusPkg;

  // One memory word, MSB is bit 0 in bus order
  typedef logic [0:`WORD_BITS-1] sbusWord_t;

  // Word address split into quadword base and word offset
  typedef struct packed {
    logic [12:33] base;
    // Offset within the quadword, steps mod 4
    logic [34:35] wo;
  } sbusQuadAddr_t;

  // Same 24 bits seen whole or as base plus offset
  typedef union packed {
    logic [12:35]  word;
    sbusQuadAddr_t quad;
  } sbusAddr_u;

  // Read request from the requester, one per phase
  typedef struct packed {
    logic                   start;
    // Word mask, bit 0 is served first
    logic [0:`QUAD_WORDS-1] rq;
    sbusAddr_u              adr;
  } sbusReq_t;

  // Response back to the requester, one per phase
  typedef struct packed {
    logic      ackn;
    logic      valid;
    sbusWord_t d;
    // Even parity over d
    logic      dataPar;
  } sbusResp_t;

endpackage
